// ==== source/gpio_pkg.sv ====
`default_nettype none

package gpio_pkg;

	// Width of one bus word.
	localparam int ARCH_W = 32;

	// Command argument width.
	// The top data bit carries the command, the rest is the argument.
	localparam int ARG_W = ARCH_W - 1;

	// Bus operation codes.
	typedef enum logic [1:0] {
		// Idle cycle, nothing happens.
		PI_NOOP = 2'b00,
		// Write the output pins.
		PI_WR   = 2'b01,
		// Read a snapshot of the inputs.
		PI_RD   = 2'b10,
		// Command with a return value.
		PI_RDWR = 2'b11
	} pi_op_e;

	// Commands, taken from the most significant data bit of a PI_RDWR.
	typedef enum logic {
		// Argument is the direction bitmap, 1 means output.
		CMD_CONFIG_IO    = 1'b0,
		// Argument is the debounce threshold in clock cycles.
		CMD_SET_DEBOUNCE = 1'b1
	} pi_cmd_e;

	// One bus request, driven by the processor every cycle.
	typedef struct packed {
		pi_op_e              op;
		logic [ARCH_W-1:0]   data;
	} pi_req_t;

endpackage

`default_nettype wire

// ==== source/gpio_debouncer.sv ====
`default_nettype none

module gpio_debouncer import gpio_pkg::*; (
	input  logic             clk_i,
	input  logic             rst_i,
	input  logic [ARG_W-1:0] thresh_i,
	input  logic             raw_i,
	output logic             clean_o
);

	// Cycles in which the raw input disagreed with the held output.
	logic [ARG_W-1:0] cnt;

	// Raw input differs from the held value.
	logic             differ;

	// Disagreement has lasted long enough.
	logic             settled;

	assign differ  = raw_i != clean_o;
	// Greater-or-equal, so lowering the threshold mid-count never wraps.
	assign settled = cnt >= thresh_i;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			cnt     <= '0;
			clean_o <= 1'b0;
		end else if (!differ) begin
			// Input agrees again, so a short glitch is forgotten.
			cnt <= '0;
		end else if (settled) begin
			// Adopt the new level and start over.
			clean_o <= raw_i;
			cnt     <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== source/gpio_inputs.sv ====
`default_nettype none

module gpio_inputs import gpio_pkg::*; #(
	parameter int IO_COUNT = 8
) (
	input  logic                clk_i,
	input  logic                rst_i,
	input  logic [IO_COUNT-1:0] pin_i,
	input  logic [IO_COUNT-1:0] dir_i,
	input  logic [ARG_W-1:0]    thresh_i,
	output logic [IO_COUNT-1:0] ival_o,
	output logic [IO_COUNT-1:0] ival_chg_o
);

	// Debounced pin levels, before masking.
	logic [IO_COUNT-1:0] clean;

	// Masked value of the previous cycle.
	logic [IO_COUNT-1:0] ival_q;

	// One debouncer per pin, all sharing the same threshold.
	for (genvar i = 0; i < IO_COUNT; i++) begin : g_dbnc
		gpio_debouncer u_dbnc (
			.clk_i    (clk_i),
			.rst_i    (rst_i),
			.thresh_i (thresh_i),
			.raw_i    (pin_i[i]),
			.clean_o  (clean[i])
		);
	end

	// Pins driven as outputs read as zero.
	assign ival_o = clean & ~dir_i;

	// Sample the masked value for edge detection.
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ival_q <= '0;
		end else begin
			ival_q <= ival_o;
		end
	end

	// Any bit that moved since last cycle, either edge.
	// A direction change that unmasks a high pin counts too.
	assign ival_chg_o = ival_o ^ ival_q;

endmodule

`default_nettype wire

// ==== source/gpio_irq.sv ====
`default_nettype none

module gpio_irq #(
	parameter int IO_COUNT = 8
) (
	input  logic                clk_i,
	input  logic                rst_i,
	input  logic [IO_COUNT-1:0] ival_chg_i,
	input  logic                irq_ack_i,
	output logic                irq_o
);

	// Sticky per-pin change flags.
	logic [IO_COUNT-1:0] flags;

	// Acknowledge of the previous cycle.
	logic                ack_q;

	// High for one cycle after the acknowledge drops.
	logic                ack_fall;

	assign ack_fall = ack_q & ~irq_ack_i;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ack_q <= 1'b0;
			flags <= '0;
		end else begin
			ack_q <= irq_ack_i;
			// Clear has priority over a change in the same cycle.
			if (ack_fall) begin
				flags <= '0;
			end else begin
				flags <= flags | ival_chg_i;
			end
		end
	end

	// Request stays up while any flag is set.
	assign irq_o = |flags;

endmodule

`default_nettype wire

// ==== source/gpio_regs.sv ====
`default_nettype none

module gpio_regs import gpio_pkg::*; #(
	parameter int IO_COUNT = 8,
	parameter int CLK_FREQ = 50000000
) (
	input  logic                clk_i,
	input  logic                rst_i,
	input  pi_req_t             pi_req_i,
	output logic [ARCH_W-1:0]   pi_data_o,
	input  logic [IO_COUNT-1:0] ival_i,
	output logic [IO_COUNT-1:0] dir_o,
	output logic [IO_COUNT-1:0] out_o,
	output logic [ARG_W-1:0]    thresh_o
);

	// Return values of the two commands.
	localparam logic [ARCH_W-1:0] IO_COUNT_RET = ARCH_W'(IO_COUNT);
	localparam logic [ARCH_W-1:0] CLK_FREQ_RET = ARCH_W'(CLK_FREQ);

	// Command field and argument of the current request.
	pi_cmd_e          cmd;
	logic [ARG_W-1:0] arg;

	// Decoded strobes, one per register load.
	logic             wr_out;
	logic             cfg_io;
	logic             set_dbnc;
	logic             rd_in;

	assign cmd = pi_cmd_e'(pi_req_i.data[ARCH_W-1]);
	assign arg = pi_req_i.data[ARG_W-1:0];

	always_comb begin
		wr_out   = 1'b0;
		cfg_io   = 1'b0;
		set_dbnc = 1'b0;
		rd_in    = 1'b0;
		unique case (pi_req_i.op)
			PI_WR:   wr_out = 1'b1;
			PI_RD:   rd_in  = 1'b1;
			PI_RDWR: begin
				// Command bit picks which register the argument goes to.
				if (cmd == CMD_CONFIG_IO) begin
					cfg_io = 1'b1;
				end else begin
					set_dbnc = 1'b1;
				end
			end
			default: ;
		endcase
	end

	// Direction and output registers.
	// Only the low IO_COUNT bits of the word are kept.
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			dir_o <= '0;
			out_o <= '0;
		end else begin
			if (cfg_io) begin
				dir_o <= arg[IO_COUNT-1:0];
			end
			if (wr_out) begin
				out_o <= pi_req_i.data[IO_COUNT-1:0];
			end
		end
	end

	// Debounce threshold, zero means one cycle of filtering.
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			thresh_o <= '0;
		end else if (set_dbnc) begin
			thresh_o <= arg;
		end
	end

	// Read data, registered one cycle after the operation.
	// Holds its value on PI_WR and PI_NOOP.
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			pi_data_o <= '0;
		end else if (rd_in) begin
			pi_data_o <= {{(ARCH_W-IO_COUNT){1'b0}}, ival_i};
		end else if (cfg_io) begin
			pi_data_o <= IO_COUNT_RET;
		end else if (set_dbnc) begin
			pi_data_o <= CLK_FREQ_RET;
		end
	end

endmodule

`default_nettype wire

// ==== source/gpio_top.sv ====
`default_nettype none

module gpio_top import gpio_pkg::*; #(
	parameter int IO_COUNT = 8,
	parameter int CLK_FREQ = 50000000
) (
	input  logic                clk_i,
	input  logic                rst_i,
	input  pi_req_t             pi_req_i,
	output logic [ARCH_W-1:0]   pi_data_o,
	output logic                irq_o,
	input  logic                irq_ack_i,
	input  logic [IO_COUNT-1:0] pin_i,
	output logic [IO_COUNT-1:0] pin_o,
	output logic [IO_COUNT-1:0] pin_oe_o
);

	// Direction, 1 means output.
	logic [IO_COUNT-1:0] dir;
	// Output pin values.
	logic [IO_COUNT-1:0] out;
	// Shared debounce threshold.
	logic [ARG_W-1:0]    thresh;
	// Masked debounced inputs.
	logic [IO_COUNT-1:0] ival;
	// Per-pin change pulses.
	logic [IO_COUNT-1:0] ival_chg;

	// Bus decoder and registers.
	gpio_regs #(
		.IO_COUNT (IO_COUNT),
		.CLK_FREQ (CLK_FREQ)
	) u_regs (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.pi_req_i  (pi_req_i),
		.pi_data_o (pi_data_o),
		.ival_i    (ival),
		.dir_o     (dir),
		.out_o     (out),
		.thresh_o  (thresh)
	);

	// Debounce, mask and change detection.
	gpio_inputs #(
		.IO_COUNT (IO_COUNT)
	) u_inputs (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.pin_i      (pin_i),
		.dir_i      (dir),
		.thresh_i   (thresh),
		.ival_o     (ival),
		.ival_chg_o (ival_chg)
	);

	// Interrupt request.
	gpio_irq #(
		.IO_COUNT (IO_COUNT)
	) u_irq (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.ival_chg_i (ival_chg),
		.irq_ack_i  (irq_ack_i),
		.irq_o      (irq_o)
	);

	// Pads are outside, so the registers go straight to the pins.
	assign pin_oe_o = dir;
	assign pin_o    = out;

endmodule

`default_nettype wire

// ==== verif/gpio_assertions.sv ====
`default_nettype none

module gpio_assertions import gpio_pkg::*; #(
	parameter int IO_COUNT = 8
) (
	input logic                clk_i,
	input logic                rst_i,
	input pi_req_t             pi_req_i,
	input logic [ARCH_W-1:0]   pi_data_o,
	input logic                irq_o,
	input logic                irq_ack_i,
	input logic [IO_COUNT-1:0] pin_o,
	input logic [IO_COUNT-1:0] pin_oe_o
);
	timeunit 1ns;
	timeprecision 1ps;

	// Failures seen so far, read by the testbench at the end.
	int fail_count = 0;

	// Pins and request idle once reset has been applied.
	reset_idle: assert property (@(posedge clk_i)
		rst_i |=> (pin_oe_o == '0 && pin_o == '0 && !irq_o))
	else begin
		$error("pins or interrupt not idle after reset");
		fail_count++;
	end

	// Idle cycle keeps the read data.
	noop_holds_data: assert property (@(posedge clk_i) disable iff (rst_i)
		pi_req_i.op == PI_NOOP |=> $stable(pi_data_o))
	else begin
		$error("pi_data_o changed after an idle cycle");
		fail_count++;
	end

	// Request only drops right after the acknowledge falls.
	irq_fall_on_ack: assert property (@(posedge clk_i) disable iff (rst_i)
		$fell(irq_o) |-> ($past(irq_ack_i, 2) && !$past(irq_ack_i)))
	else begin
		$error("irq_o fell without an acknowledge falling edge");
		fail_count++;
	end

endmodule

bind gpio_top gpio_assertions #(
	.IO_COUNT (IO_COUNT)
) u_assert (
	.clk_i     (clk_i),
	.rst_i     (rst_i),
	.pi_req_i  (pi_req_i),
	.pi_data_o (pi_data_o),
	.irq_o     (irq_o),
	.irq_ack_i (irq_ack_i),
	.pin_o     (pin_o),
	.pin_oe_o  (pin_oe_o)
);

`default_nettype wire

// ==== verif/tb_gpio_top.sv ====
`default_nettype none

module tb_gpio_top import gpio_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int IO_COUNT       = 8;
	localparam int CLK_FREQ       = 50000000;
	localparam int THRESH         = 5;
	// About 100 cycles of tests, with a wide margin.
	localparam int TIMEOUT_CYCLES = 2000;

	logic                clk;
	logic                rst;
	pi_req_t             pi_req;
	logic [ARCH_W-1:0]   pi_data;
	logic                irq;
	logic                irq_ack;
	logic [IO_COUNT-1:0] pin_in;
	logic [IO_COUNT-1:0] pin_out;
	logic [IO_COUNT-1:0] pin_oe;

	// Expected read data and direction, tracked from the bus rules.
	logic [ARCH_W-1:0]   exp_data;
	logic [IO_COUNT-1:0] exp_dir;
	integer              seed;

	gpio_top #(
		.IO_COUNT (IO_COUNT),
		.CLK_FREQ (CLK_FREQ)
	) uut (
		.clk_i     (clk),
		.rst_i     (rst),
		.pi_req_i  (pi_req),
		.pi_data_o (pi_data),
		.irq_o     (irq),
		.irq_ack_i (irq_ack),
		.pin_i     (pin_in),
		.pin_o     (pin_out),
		.pin_oe_o  (pin_oe)
	);

	// 20 ns period.
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Guard against a hung run.
	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Errors found");
		$fatal(1, "Simulation timed out");
	end

	task automatic compare(input string name, input logic [ARCH_W-1:0] got,
		input logic [ARCH_W-1:0] exp);
		if (got !== exp) begin
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("Errors found");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	// One bus operation, started and ended on a falling edge.
	task automatic bus_op(input pi_op_e op, input logic [ARCH_W-1:0] data);
		pi_req = '{op: op, data: data};
		@(negedge clk);
		pi_req = '{op: PI_NOOP, data: '0};
	endtask

	// Direction command, 1 means output; returns the pin count.
	task automatic set_directions(input logic [IO_COUNT-1:0] map);
		bus_op(PI_RDWR, {CMD_CONFIG_IO, ARG_W'(map)});
		exp_dir  = map;
		exp_data = ARCH_W'(IO_COUNT);
		compare("pi_data_o", pi_data, exp_data);
		compare("pin_oe_o", pin_oe, exp_dir);
	endtask

	// Snapshot read, expected value is the pins with outputs masked off.
	task automatic read_inputs(input logic [IO_COUNT-1:0] pins);
		bus_op(PI_RD, '0);
		exp_data = ARCH_W'(pins & ~exp_dir);
		compare("pi_data_o", pi_data, exp_data);
	endtask

	task automatic check_reset_state();
		compare("pin_o", pin_out, '0);
		compare("pin_oe_o", pin_oe, '0);
		compare("irq_o", irq, 1'b0);
		exp_dir = '0;
		read_inputs('0);
	endtask

	task automatic write_outputs();
		logic [ARCH_W-1:0] rnd;
		rnd = $random(seed);
		bus_op(PI_WR, rnd);
		compare("pin_o", pin_out, rnd[IO_COUNT-1:0]);
		// Write leaves the read data alone.
		compare("pi_data_o", pi_data, exp_data);
	endtask

	task automatic debounce_and_read();
		logic [ARCH_W-1:0]   rnd;
		logic [IO_COUNT-1:0] pattern;
		set_directions('0);
		bus_op(PI_RDWR, {CMD_SET_DEBOUNCE, ARG_W'(THRESH)});
		exp_data = ARCH_W'(CLK_FREQ);
		compare("pi_data_o", pi_data, exp_data);
		// Glitch shorter than the threshold, read while it is still high.
		pin_in[0] = 1'b1;
		wait_cycles(2);
		read_inputs('0);
		pin_in[0] = 1'b0;
		wait_cycles(THRESH + 2);
		read_inputs('0);
		// Held level well past thresh + 1 cycles.
		rnd = $random(seed);
		pattern = rnd[IO_COUNT-1:0] | 8'h01;
		pin_in = pattern;
		wait_cycles(10);
		read_inputs(pattern);
		rnd = $random(seed);
		// Pin 0 is high, so at least one output pin is masked.
		set_directions(rnd[IO_COUNT-1:0] | 8'h01);
		read_inputs(pattern);
	endtask

	task automatic interrupt_flow();
		int waited;
		// Quiet inputs, then drop anything left pending.
		pin_in = '0;
		set_directions('0);
		wait_cycles(THRESH + 5);
		irq_ack = 1'b1;
		wait_cycles(1);
		irq_ack = 1'b0;
		wait_cycles(1);
		compare("irq_o", irq, 1'b0);
		pin_in[2] = 1'b1;
		waited = 0;
		while (!irq && waited < THRESH + 3) begin
			@(negedge clk);
			waited++;
		end
		compare("irq_o", irq, 1'b1);
		wait_cycles(4);
		compare("irq_o", irq, 1'b1);
		// High acknowledge alone does not clear.
		irq_ack = 1'b1;
		wait_cycles(3);
		compare("irq_o", irq, 1'b1);
		irq_ack = 1'b0;
		compare("irq_o", irq, 1'b1);
		wait_cycles(1);
		compare("irq_o", irq, 1'b0);
		// Pin 4 as output, its input side is masked.
		set_directions(8'h10);
		repeat (3) begin
			pin_in[4] = ~pin_in[4];
			wait_cycles(THRESH + 3);
			compare("irq_o", irq, 1'b0);
		end
	endtask

	initial begin
		seed     = 32'h6d5d;
		rst      = 1'b1;
		pi_req   = '{op: PI_NOOP, data: '0};
		irq_ack  = 1'b0;
		pin_in   = '0;
		exp_data = '0;
		exp_dir  = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		check_reset_state();
		set_directions(IO_COUNT'($random(seed)));
		write_outputs();
		debounce_and_read();
		interrupt_flow();
		wait_cycles(2);
		if (uut.u_assert.fail_count == 0) begin
			$display("No errors");
			$finish;
		end else begin
			$display("Errors found");
			$fatal(1, "Bound assertions failed");
		end
	end

endmodule

`default_nettype wire

// ==== files.f ====
source/gpio_pkg.sv
source/gpio_debouncer.sv
source/gpio_inputs.sv
source/gpio_irq.sv
source/gpio_regs.sv
source/gpio_top.sv
verif/gpio_assertions.sv
verif/tb_gpio_top.sv
